// ==== dhcp_client.f ====
dhcp_pkg.sv
dhcp_prng.sv
dhcp_opt_asm.sv
dhcp_tx.sv
dhcp_client_fsm.sv
dhcp_client.sv
tb_dhcp_client.sv

// ==== dhcp_client.sv ====
module dhcp_client (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                start,
  input  dhcp_pkg::mac_addr_t mac_addr,
  input  logic                offer_val,
  input  dhcp_pkg::ip_addr_t  offer_ip,
  input  logic                ack_val,
  input  logic                udp_req,
  output logic                udp_rdy,
  output logic                udp_val,
  output logic                udp_sof,
  output logic                udp_eof,
  output dhcp_pkg::byte_t     udp_dat,
  output dhcp_pkg::port_t     udp_src_port,
  output dhcp_pkg::port_t     udp_dst_port,
  output dhcp_pkg::len_t      udp_length,
  output dhcp_pkg::ip_addr_t  ipv4_src_ip,
  output dhcp_pkg::ip_addr_t  ipv4_dst_ip,
  output logic [15:0]         ipv4_id,
  output logic                bound,
  output dhcp_pkg::ip_addr_t  lease_ip
);
  import dhcp_pkg::*;

  logic      tx_val;      // fsm to transmitter
  msg_type_t tx_msg_type;
  opt_pres_t tx_opt_pres;
  ip_addr_t  tx_req_ip;
  xid_t      tx_xid;
  logic      tx_busy;     // transmitter back to fsm
  logic      tx_done;

  dhcp_client_fsm u_fsm (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .start       (start),
    .offer_val   (offer_val),
    .offer_ip    (offer_ip),
    .ack_val     (ack_val),
    .tx_busy     (tx_busy),
    .tx_done     (tx_done),
    .tx_val      (tx_val),
    .tx_msg_type (tx_msg_type),
    .tx_opt_pres (tx_opt_pres),
    .tx_req_ip   (tx_req_ip),
    .tx_xid      (tx_xid),
    .bound       (bound),
    .lease_ip    (lease_ip)
  );

  dhcp_tx u_tx (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .tx_val       (tx_val),
    .tx_msg_type  (tx_msg_type),
    .tx_opt_pres  (tx_opt_pres),
    .tx_req_ip    (tx_req_ip),
    .tx_xid       (tx_xid),
    .mac_addr     (mac_addr),
    .udp_req      (udp_req),
    .udp_rdy      (udp_rdy),
    .udp_val      (udp_val),
    .udp_sof      (udp_sof),
    .udp_eof      (udp_eof),
    .udp_dat      (udp_dat),
    .udp_src_port (udp_src_port),
    .udp_dst_port (udp_dst_port),
    .udp_length   (udp_length),
    .ipv4_src_ip  (ipv4_src_ip),
    .ipv4_dst_ip  (ipv4_dst_ip),
    .ipv4_id      (ipv4_id),
    .tx_busy      (tx_busy),
    .tx_done      (tx_done)
  );

endmodule

// ==== dhcp_client_fsm.sv ====
module dhcp_client_fsm (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                start,
  input  logic                offer_val,
  input  dhcp_pkg::ip_addr_t  offer_ip,
  input  logic                ack_val,
  input  logic                tx_busy,
  input  logic                tx_done,
  output logic                tx_val,
  output dhcp_pkg::msg_type_t tx_msg_type,
  output dhcp_pkg::opt_pres_t tx_opt_pres,
  output dhcp_pkg::ip_addr_t  tx_req_ip,
  output dhcp_pkg::xid_t      tx_xid,
  output logic                bound,
  output dhcp_pkg::ip_addr_t  lease_ip
);
  import dhcp_pkg::*;

  client_state_t          state;
  xid_t                   prng_val;
  ip_addr_t               offer_ip_r; // address from the last offer
  logic                   sent;       // frame fully out, retry window open
  logic [RETRY_CNT_W-1:0] retry_cnt;
  logic                   timeout;
  logic                   send;       // tx_val goes out this edge

  assign timeout = sent & (retry_cnt == RETRY_CNT_W'(RETRY_TICKS - 1));
  assign send    = ((state == st_discover) | (state == st_request)) & ~tx_busy;

  dhcp_prng u_prng (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .prng_val (prng_val)
  );

  ////////////////////
  // exchange fsm
  ////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= st_idle;
      tx_val    <= 1'b0;
      bound     <= 1'b0;
      sent      <= 1'b0;
      retry_cnt <= '0;
    end else begin
      tx_val <= send;                       // single-cycle pulse
      if (tx_done) sent <= 1'b1;
      if (sent) retry_cnt <= retry_cnt + 1'b1;
      if (send) begin
        sent      <= 1'b0;                  // window restarts per frame
        retry_cnt <= '0;
      end
      case (state)
        st_idle:       if (start) state <= st_discover;
        st_discover:   if (send) state <= st_wait_offer;
        st_wait_offer: begin
          if (offer_val) state <= st_request;
          else if (timeout) state <= st_discover; // resend with new xid
        end
        st_request:    if (send) state <= st_wait_ack;
        st_wait_ack: begin
          if (ack_val) begin
            bound <= 1'b1;
            state <= st_bound;
          end else if (timeout) begin
            state <= st_discover;
          end
        end
        st_bound:      sent <= 1'b0;        // no renewal, timer parked
        default:       state <= st_idle;
      endcase
    end
  end

  ////////////////////
  // message fields
  ////////////////////
  always_ff @(posedge clk) begin
    if (send && state == st_discover) begin
      tx_xid      <= prng_val;              // fresh xid per discover
      tx_msg_type <= dhcp_discover;
      tx_opt_pres <= PRES_DISCOVER;
      tx_req_ip   <= IPV4_ANY;
    end
    if (send && state == st_request) begin
      tx_msg_type <= dhcp_request;          // xid kept from discover
      tx_opt_pres <= PRES_REQUEST;
      tx_req_ip   <= offer_ip_r;
    end
    if (state == st_wait_offer && offer_val) offer_ip_r <= offer_ip;
    if (state == st_wait_ack && ack_val) lease_ip <= offer_ip_r;
  end

  // transmitter drops requests that arrive mid-frame
  a_no_val_when_busy : assert property (
    @(posedge clk) disable iff (fsm_rst)
    tx_val |-> !tx_busy
  );

endmodule

// ==== dhcp_opt_asm.sv ====
module dhcp_opt_asm (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  tx_val,
  input  dhcp_pkg::msg_type_t   msg_type,
  input  dhcp_pkg::ip_addr_t    req_ip,
  input  dhcp_pkg::mac_addr_t   mac_addr,
  input  dhcp_pkg::opt_pres_t   opt_pres,
  output logic [0:dhcp_pkg::OPT_NUM_TX-1][dhcp_pkg::OPT_LEN-1:0][7:0] opt_slots,
  output dhcp_pkg::len_t        opt_len,
  output logic                  opt_rdy
);
  import dhcp_pkg::*;

  logic [0:OPT_NUM_TX-1][OPT_LEN-1:0][7:0] proto; // prototype slots, slot 0 first
  opt_pres_t                               pres;  // shifted with proto
  logic [OPT_CNT_W-1:0]                    opt_cnt;
  logic                                    shift_opt;
  logic                                    last_shift;

  assign last_shift = (opt_cnt == OPT_CNT_W'(OPT_NUM_TX - 1));

  ////////////////////
  // control
  ////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      shift_opt <= 1'b0;
      opt_cnt   <= '0;
      opt_rdy   <= 1'b0;
      pres      <= '0;
      opt_len   <= '0;
    end else begin
      if (tx_val) begin
        shift_opt <= 1'b1;     // start packing next cycle
        opt_cnt   <= '0;
        opt_len   <= '0;
        pres      <= opt_pres;
      end else if (shift_opt) begin
        opt_cnt <= opt_cnt + 1'b1;
        pres    <= {pres[OPT_NUM_TX-2:0], 1'b0}; // top bit is slot under test
        if (pres[OPT_NUM_TX-1]) begin
          opt_len <= opt_len + len_t'(OPT_LEN);
        end
        if (last_shift) begin
          shift_opt <= 1'b0;
          opt_rdy   <= 1'b1;   // held until next reset
        end
      end
    end
  end

  ////////////////////
  // slot packing
  ////////////////////
  // slots are walked from the end option back to message type, each present
  // one is pushed in at index 0, so present slots land contiguous from slot 0
  always_ff @(posedge clk) begin
    if (tx_val) begin
      proto <= {
        {OPT_MSG_TYPE, OPT_MSG_TYPE_LEN, byte_t'(msg_type),
         {(OPT_LEN - OPT_MSG_TYPE_LEN - 2){OPT_PAD}}},
        {OPT_REQ_IP, OPT_REQ_IP_LEN, req_ip,
         {(OPT_LEN - OPT_REQ_IP_LEN - 2){OPT_PAD}}},
        {OPT_CLIENT_ID, OPT_CLIENT_ID_LEN, HTYPE_ETH, mac_addr,
         {(OPT_LEN - OPT_CLIENT_ID_LEN - 2){OPT_PAD}}},
        {OPT_HOSTNAME, HOSTNAME_LEN, HOSTNAME,
         {(OPT_LEN - HOSTNAME_LEN - 2){OPT_PAD}}},
        {OPT_END, {(OPT_LEN - 1){OPT_PAD}}}
      };
      opt_slots <= '0;         // absent tail reads as padding
    end else if (shift_opt) begin
      proto[1:OPT_NUM_TX-1] <= proto[0:OPT_NUM_TX-2];
      if (pres[OPT_NUM_TX-1]) begin
        opt_slots[1:OPT_NUM_TX-1] <= opt_slots[0:OPT_NUM_TX-2];
        opt_slots[0]              <= proto[OPT_NUM_TX-1];
      end
    end
  end

  // a frame without the end option is malformed on the wire
  a_end_present : assert property (
    @(posedge clk) disable iff (fsm_rst)
    tx_val |-> opt_pres[SLOT_END]
  );

endmodule

// ==== dhcp_pkg.sv ====
package dhcp_pkg;

  ////////////////////
  // basic widths
  ////////////////////
  typedef logic [7:0]  byte_t;     // one frame byte
  typedef logic [31:0] ip_addr_t;  // ipv4 address
  typedef logic [47:0] mac_addr_t; // ethernet address
  typedef logic [31:0] xid_t;      // dhcp transaction id
  typedef logic [15:0] port_t;     // udp port
  typedef logic [15:0] len_t;      // byte length

  typedef enum logic [7:0] {
    dhcp_discover = 8'd1,
    dhcp_offer    = 8'd2,
    dhcp_request  = 8'd3,
    dhcp_ack      = 8'd5
  } msg_type_t;

  typedef enum logic [2:0] {
    st_idle,
    st_discover,
    st_wait_offer,
    st_request,
    st_wait_ack,
    st_bound
  } client_state_t;

  ////////////////////
  // frame geometry
  ////////////////////
  localparam int DHCP_HDR_LEN   = 240;                     // bootp fields plus cookie
  localparam int OPT_LEN        = 16;                      // bytes per option slot
  localparam int OPT_NUM_TX     = 5;                       // slots per frame
  localparam int OPT_TOT_LEN_TX = OPT_NUM_TX * OPT_LEN;
  localparam int FRAME_MAX_LEN  = DHCP_HDR_LEN + OPT_TOT_LEN_TX;
  localparam int OPT_CNT_W      = $clog2(OPT_NUM_TX);      // slot shift counter
  localparam int CHADDR_PAD_LEN = 10;                      // chaddr is 16 bytes, mac is 6
  localparam int SNAME_LEN      = 64;
  localparam int FILE_LEN       = 128;

  typedef logic [OPT_NUM_TX-1:0] opt_pres_t; // bit i set means slot i present

  localparam int        SLOT_END      = 4;           // end option always last
  localparam opt_pres_t PRES_DISCOVER = 5'b11101;    // no requested ip
  localparam opt_pres_t PRES_REQUEST  = 5'b11111;

  ////////////////////
  // option codes
  ////////////////////
  localparam byte_t OPT_PAD           = 8'd0;
  localparam byte_t OPT_HOSTNAME      = 8'd12;
  localparam byte_t OPT_REQ_IP        = 8'd50;
  localparam byte_t OPT_MSG_TYPE      = 8'd53;
  localparam byte_t OPT_CLIENT_ID     = 8'd61;
  localparam byte_t OPT_END           = 8'd255;
  localparam byte_t OPT_MSG_TYPE_LEN  = 8'd1;
  localparam byte_t OPT_REQ_IP_LEN    = 8'd4;
  localparam byte_t OPT_CLIENT_ID_LEN = 8'd7;        // hw type byte plus mac

  localparam byte_t HOSTNAME_LEN = 8'd8;
  localparam logic [0:HOSTNAME_LEN-1][7:0] HOSTNAME = "fpgacli1";

  ////////////////////
  // bootp and udp
  ////////////////////
  localparam byte_t       BOOTP_OP_REQ = 8'd1;       // boot request
  localparam byte_t       HTYPE_ETH    = 8'd1;       // also client id type
  localparam byte_t       HLEN_ETH     = 8'd6;
  localparam logic [15:0] BOOTP_FLAGS  = 16'h8000;   // broadcast reply wanted
  localparam logic [31:0] MAGIC_COOKIE = 32'h6382_5363;

  localparam port_t    DHCP_CLI_PORT = 16'd68;
  localparam port_t    DHCP_SRV_PORT = 16'd67;
  localparam int       UDP_HDR_LEN   = 8;
  localparam ip_addr_t IPV4_ANY      = 32'h0000_0000;
  localparam ip_addr_t IPV4_BCAST    = 32'hffff_ffff;

  ////////////////////
  // timing and prng
  ////////////////////
  localparam int   RETRY_TICKS = 400;                 // offer/ack timeout in cycles
  localparam int   RETRY_CNT_W = $clog2(RETRY_TICKS);
  localparam xid_t PRNG_SEED   = 32'h1d87_2b41;       // any nonzero value
  localparam xid_t PRNG_TAPS   = 32'h8020_0003;       // x^32+x^22+x^2+x+1

endpackage

// ==== dhcp_prng.sv ====
module dhcp_prng (
  input  logic           clk,
  input  logic           fsm_rst,
  output dhcp_pkg::xid_t prng_val
);
  import dhcp_pkg::*;

  logic feedback; // bit shifted out this cycle

  assign feedback = prng_val[0];

  // galois form, right shift with taps folded in
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      prng_val <= PRNG_SEED; // nonzero seed
    end else begin
      prng_val <= (prng_val >> 1) ^ ({$bits(xid_t){feedback}} & PRNG_TAPS);
    end
  end

  // all-zero state would lock up, xids would repeat forever
  a_prng_nonzero : assert property (
    @(posedge clk) disable iff (fsm_rst)
    prng_val != '0
  );

endmodule

// ==== dhcp_tx.sv ====
module dhcp_tx (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                tx_val,
  input  dhcp_pkg::msg_type_t tx_msg_type,
  input  dhcp_pkg::opt_pres_t tx_opt_pres,
  input  dhcp_pkg::ip_addr_t  tx_req_ip,
  input  dhcp_pkg::xid_t      tx_xid,
  input  dhcp_pkg::mac_addr_t mac_addr,
  input  logic                udp_req,
  output logic                udp_rdy,
  output logic                udp_val,
  output logic                udp_sof,
  output logic                udp_eof,
  output dhcp_pkg::byte_t     udp_dat,
  output dhcp_pkg::port_t     udp_src_port,
  output dhcp_pkg::port_t     udp_dst_port,
  output dhcp_pkg::len_t      udp_length,
  output dhcp_pkg::ip_addr_t  ipv4_src_ip,
  output dhcp_pkg::ip_addr_t  ipv4_dst_ip,
  output logic [15:0]         ipv4_id,
  output logic                tx_busy,
  output logic                tx_done
);
  import dhcp_pkg::*;

  logic                                    tx_rst;    // external or end-of-frame reset
  logic                                    rst_reg;   // set with eof
  logic                                    opt_rdy;
  logic                                    append;    // options ready, not yet loaded
  logic                                    shift;     // one byte out this edge
  logic [0:OPT_NUM_TX-1][OPT_LEN-1:0][7:0] opt_slots;
  len_t                                    opt_len;
  len_t                                    frame_len;
  len_t                                    byte_cnt;
  logic [0:FRAME_MAX_LEN-1][7:0]           frame_buf; // byte 0 goes out next
  logic [15:0]                             id_cnt;

  assign tx_rst    = fsm_rst | rst_reg;
  assign append    = opt_rdy & ~udp_rdy;
  assign shift     = udp_rdy & udp_req;
  assign frame_len = len_t'(DHCP_HDR_LEN) + opt_len;
  assign tx_done   = udp_eof; // fsm starts its retry window here

  dhcp_opt_asm u_opt_asm (
    .clk       (clk),
    .fsm_rst   (tx_rst),
    .tx_val    (tx_val),
    .msg_type  (tx_msg_type),
    .req_ip    (tx_req_ip),
    .mac_addr  (mac_addr),
    .opt_pres  (tx_opt_pres),
    .opt_slots (opt_slots),
    .opt_len   (opt_len),
    .opt_rdy   (opt_rdy)
  );

  ////////////////////
  // stream control
  ////////////////////
  always_ff @(posedge clk) begin
    if (tx_rst) begin
      rst_reg  <= 1'b0;
      tx_busy  <= 1'b0;
      udp_rdy  <= 1'b0;
      udp_val  <= 1'b0;
      udp_sof  <= 1'b0;
      udp_eof  <= 1'b0;
      byte_cnt <= '0;
    end else begin
      udp_val <= 1'b0; // strobes default low
      udp_sof <= 1'b0;
      udp_eof <= 1'b0;
      if (tx_val) tx_busy <= 1'b1;
      if (append) udp_rdy <= 1'b1; // one cycle after opt_rdy
      if (shift) begin
        udp_val  <= 1'b1;
        udp_sof  <= (byte_cnt == '0);
        byte_cnt <= byte_cnt + 1'b1;
        if (byte_cnt == frame_len - 1'b1) begin
          udp_eof <= 1'b1;
          rst_reg <= 1'b1;         // clears everything next edge
        end
      end
    end
  end

  ////////////////////
  // frame buffer
  ////////////////////
  always_ff @(posedge clk) begin
    if (tx_val) begin
      frame_buf[0:DHCP_HDR_LEN-1] <= {
        BOOTP_OP_REQ, HTYPE_ETH, HLEN_ETH, 8'd0, // op htype hlen hops
        tx_xid,
        16'd0, BOOTP_FLAGS,                      // secs flags
        IPV4_ANY, IPV4_ANY, IPV4_ANY, IPV4_ANY,  // ciaddr yiaddr siaddr giaddr
        mac_addr, {CHADDR_PAD_LEN{8'h00}},
        {SNAME_LEN{8'h00}},
        {FILE_LEN{8'h00}},
        MAGIC_COOKIE
      };
    end else if (append) begin
      frame_buf[DHCP_HDR_LEN:FRAME_MAX_LEN-1] <= opt_slots;
      udp_src_port <= DHCP_CLI_PORT;
      udp_dst_port <= DHCP_SRV_PORT;
      udp_length   <= frame_len + len_t'(UDP_HDR_LEN);
      ipv4_src_ip  <= IPV4_ANY;     // no address before bound
      ipv4_dst_ip  <= IPV4_BCAST;
      ipv4_id      <= id_cnt;
    end else if (shift) begin
      frame_buf[0:FRAME_MAX_LEN-2] <= frame_buf[1:FRAME_MAX_LEN-1];
      udp_dat                      <= frame_buf[0];
    end
  end

  // ipv4 id survives the per-frame reset
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      id_cnt <= '0;
    end else if (append) begin
      id_cnt <= id_cnt + 1'b1;
    end
  end

  // downstream only sees data it pulled
  a_val_after_req : assert property (
    @(posedge clk) disable iff (fsm_rst)
    !udp_req |=> !udp_val
  );

endmodule

// ==== tb_dhcp_client.sv ====
module tb_dhcp_client;
  import dhcp_pkg::*;

  localparam int        CLK_HALF        = 20;                   // 40 unit period
  localparam int        N_FRAMES        = 3;                    // discover, retry, request
  localparam int        FRAME_WAIT      = 4 * FRAME_MAX_LEN + RETRY_TICKS + 100;
  localparam int        WATCHDOG_CYCLES = 4 * N_FRAMES * (2 * FRAME_MAX_LEN + RETRY_TICKS);
  localparam mac_addr_t MAC             = 48'h02_1a_2b_3c_4d_5e;
  localparam ip_addr_t  OFFER           = 32'hc0a8_0117;        // 192.168.1.23

  logic clk, fsm_rst, start, offer_val, ack_val, udp_req;
  logic udp_rdy, udp_val, udp_sof, udp_eof, bound;
  mac_addr_t   mac_addr;
  ip_addr_t    offer_ip, ipv4_src_ip, ipv4_dst_ip, lease_ip;
  byte_t       udp_dat;
  port_t       udp_src_port, udp_dst_port;
  len_t        udp_length;
  logic [15:0] ipv4_id;

  logic [31:0] lfsr = 32'hc266_625a;     // back-pressure source
  int errors = 0, tests_run = 0, tests_failed = 0;

  ////////////////////
  // capture model state
  ////////////////////
  byte_t       cap [0:FRAME_MAX_LEN-1]; // bytes of the last frame
  int          byte_idx = 0;
  logic        in_frame = 1'b0;
  int          cap_len = 0, frames_seen = 0, sof_total = 0, eof_total = 0;
  int          cycle_cnt = 0, sof_cycle = 0, eof_cycle = 0, stall_cnt = 0;
  len_t        meta_length;
  port_t       meta_src_port, meta_dst_port;
  ip_addr_t    meta_src_ip, meta_dst_ip;
  logic [15:0] meta_id;

  dhcp_client u_dhcp_client (
    .clk (clk), .fsm_rst (fsm_rst), .start (start), .mac_addr (mac_addr),
    .offer_val (offer_val), .offer_ip (offer_ip), .ack_val (ack_val),
    .udp_req (udp_req), .udp_rdy (udp_rdy), .udp_val (udp_val), .udp_sof (udp_sof),
    .udp_eof (udp_eof), .udp_dat (udp_dat), .udp_src_port (udp_src_port),
    .udp_dst_port (udp_dst_port), .udp_length (udp_length),
    .ipv4_src_ip (ipv4_src_ip), .ipv4_dst_ip (ipv4_dst_ip), .ipv4_id (ipv4_id),
    .bound (bound), .lease_ip (lease_ip)
  );

  always #(CLK_HALF) clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ ({32{s[0]}} & 32'ha300_0000); // right-shift galois step
  endfunction

  always @(posedge clk) begin
    lfsr    <= lfsr_next(lfsr);          // one step per bit taken
    udp_req <= lfsr[0];
  end

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // frame capture between sof and eof
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (!fsm_rst && udp_rdy && !udp_req) stall_cnt <= stall_cnt + 1; // paused cycles
    if (!fsm_rst && udp_val) begin
      if (udp_sof) begin
        if (in_frame) begin
          $display("[ERROR] %0t: a second sof arrived inside one frame", $time);
          errors++;
        end
        in_frame   = 1'b1;
        byte_idx   = 0;
        sof_total <= sof_total + 1;
        sof_cycle <= cycle_cnt;
      end else if (!in_frame) begin
        $display("[ERROR] %0t: a byte arrived outside any frame", $time);
        errors++;
      end
      if (byte_idx < FRAME_MAX_LEN) cap[byte_idx] <= udp_dat;
      byte_idx++;
      if (udp_eof) begin
        in_frame       = 1'b0;
        cap_len       <= byte_idx;
        eof_total     <= eof_total + 1;
        eof_cycle     <= cycle_cnt;
        meta_length   <= udp_length;     // metadata still held on the eof cycle
        meta_src_port <= udp_src_port;
        meta_dst_port <= udp_dst_port;
        meta_src_ip   <= ipv4_src_ip;
        meta_dst_ip   <= ipv4_dst_ip;
        meta_id       <= ipv4_id;
        frames_seen   <= frames_seen + 1;
      end
    end
  end

  ////////////////////
  // protocol assertions
  ////////////////////
  a_val_follows_req : assert property (@(posedge clk) disable iff (fsm_rst)
    udp_val |-> $past(udp_req)) else begin
    $display("[ERROR] %0t: udp_val was high without udp_req on the cycle before", $time);
    errors++;
  end

  a_marks_with_val : assert property (@(posedge clk) disable iff (fsm_rst)
    (udp_sof || udp_eof) |-> udp_val) else begin
    $display("[ERROR] %0t: sof or eof was high without udp_val", $time);
    errors++;
  end

  a_meta_held : assert property (@(posedge clk) disable iff (fsm_rst)
    (udp_rdy && $past(udp_rdy)) |-> ($stable(udp_length) && $stable(ipv4_id))) else begin
    $display("[ERROR] %0t: frame metadata changed while udp_rdy was high", $time);
    errors++;
  end

  a_drop_after_eof : assert property (@(posedge clk) disable iff (fsm_rst)
    udp_eof |=> (!udp_rdy && !udp_val)) else begin
    $display("[ERROR] %0t: udp_rdy or udp_val still high the cycle after eof", $time);
    errors++;
  end

  task automatic wait_frame(input int n);
    int waited;
    waited = 0;
    while (frames_seen < n && waited < FRAME_WAIT) begin
      @(posedge clk);
      waited++;
    end
    if (frames_seen < n) begin
      $display("[ERROR] %0t: frame %0d did not arrive within %0d cycles", $time, n, FRAME_WAIT);
      errors++;
    end
  endtask

  // header, metadata and option slots against the bootp/dhcp layout
  task automatic check_frame(input logic [7:0] exp_type, input int exp_len,
                             input int exp_hits, input ip_addr_t exp_req_ip,
                             output logic [31:0] xid);
    int hits;
    int base;
    hits = 0;
    expect_eq("frame length", cap_len, exp_len);
    expect_eq("udp_length", meta_length, exp_len + 8);
    expect_eq("udp ports", {meta_src_port, meta_dst_port}, {16'd68, 16'd67});
    expect_eq("ipv4_src_ip", meta_src_ip, 32'h0);
    expect_eq("ipv4_dst_ip", meta_dst_ip, 32'hffff_ffff);
    expect_eq("op htype hlen hops", {cap[0], cap[1], cap[2], cap[3]}, 32'h0101_0600);
    xid = {cap[4], cap[5], cap[6], cap[7]};
    expect_eq("flags", {cap[10], cap[11]}, 16'h8000);
    for (int i = 12; i < 28; i++) expect_eq("address fields", cap[i], 8'h00);
    expect_eq("chaddr upper", {cap[28], cap[29], cap[30], cap[31]}, MAC[47:16]);
    expect_eq("chaddr lower", {cap[32], cap[33]}, MAC[15:0]);
    expect_eq("magic cookie", {cap[236], cap[237], cap[238], cap[239]}, 32'h6382_5363);
    expect_eq("slot 0 head", {cap[240], cap[241], cap[242]}, {8'd53, 8'd1, exp_type});
    for (int i = 243; i < 256; i++) expect_eq("slot 0 padding", cap[i], 8'h00);
    for (int s = 0; s < (exp_len - 240) / 16; s++) begin
      base = 240 + 16 * s;
      if (cap[base] == 8'd50) begin  // requested ip slot
        hits++;
        expect_eq("requested ip length", cap[base+1], 8'd4);
        expect_eq("requested ip", {cap[base+2], cap[base+3], cap[base+4], cap[base+5]},
                  exp_req_ip);
      end
    end
    expect_eq("slots with code 50", hits, exp_hits);
    expect_eq("last slot code", cap[exp_len-16], 8'd255);
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - err_before);
    end
  endtask

  initial begin
    int          e0;
    int          eof1;
    int          n;
    logic [31:0] xid1, xid2, xid3;
    logic [15:0] id2;
    clk       = 1'b0;
    fsm_rst   = 1'b1;
    start     = 1'b0;
    mac_addr  = MAC;
    offer_val = 1'b0;
    offer_ip  = '0;
    ack_val   = 1'b0;
    udp_req   = 1'b0;
    repeat (3) @(posedge clk);
    fsm_rst <= 1'b0;

    e0 = errors;                          // idle after reset
    repeat (10) begin
      @(posedge clk);
      expect_eq("idle outputs", {udp_rdy, udp_val, udp_sof, udp_eof, bound}, 5'b0);
    end
    report_test("reset_idle", e0);

    e0 = errors;                          // first discover
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    wait_frame(1);
    check_frame(8'd1, 304, 0, '0, xid1);
    eof1 = eof_cycle;
    report_test("discover", e0);

    e0 = errors;                          // pull protocol under random udp_req
    expect_eq("sof count", sof_total, 1);
    expect_eq("eof count", eof_total, 1);
    expect_eq("back-pressure seen", stall_cnt != 0, 1'b1);
    report_test("back_pressure", e0);

    e0 = errors;                          // no offer, discover repeats
    wait_frame(2);
    check_frame(8'd1, 304, 0, '0, xid2);
    expect_eq("retry gap covers timeout", (sof_cycle - eof1) >= RETRY_TICKS, 1'b1);
    expect_eq("fresh xid on retry", xid2 != xid1, 1'b1);
    expect_eq("sof and eof per frame", {sof_total[7:0], eof_total[7:0]}, 16'h0202);
    id2 = meta_id;
    report_test("retry", e0);

    e0 = errors;                          // offer leads to request
    offer_val <= 1'b1;
    offer_ip  <= OFFER;
    @(posedge clk);
    offer_val <= 1'b0;
    wait_frame(3);
    check_frame(8'd3, 320, 1, OFFER, xid3);
    expect_eq("request xid", xid3, xid2);
    expect_eq("request ipv4_id", meta_id, id2 + 16'd1);
    report_test("request", e0);

    e0 = errors;                          // ack binds the lease
    expect_eq("bound before ack", bound, 1'b0);
    ack_val <= 1'b1;
    @(posedge clk);
    ack_val <= 1'b0;
    n = 0;
    while (!bound && n < 8) begin
      @(posedge clk);
      n++;
    end
    expect_eq("bound after ack", bound, 1'b1);
    expect_eq("lease_ip", lease_ip, OFFER);
    report_test("bound", e0);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // ends a stuck run
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
